/* src/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// geometry of the two-way cache for a 16-bit byte address
// the tag sits on top, then the set index, then the byte offset in a block
`define CACHE_TAG_BITS   6
`define CACHE_SET_BITS   6

// eight 16-bit words make up one 16-byte block
`define CACHE_WORD_BITS  3
`define CACHE_WORD_WIDTH 16

// full byte address width, the extra bit selects a byte inside a word
`define CACHE_ADDR_BITS  (`CACHE_TAG_BITS + `CACHE_SET_BITS + `CACHE_WORD_BITS + 1)

// main memory answers a read strobe after this many cycles
`define CACHE_MEM_LATENCY 4

`endif

/* src/cachePkg.sv */
`include "cache_params.svh"

package cachePkg;

   // one data word as seen by the CPU, the cache and main memory
   typedef logic [`CACHE_WORD_WIDTH-1:0] wordT;

   // lookup view of an address, used to index the tag stores
   typedef struct packed {
      logic [`CACHE_TAG_BITS-1:0]  tag;
      logic [`CACHE_SET_BITS-1:0]  set;
      logic [`CACHE_WORD_BITS:0]   offset;
   } lookupAddrT;

   // fill view of the same address
   // blockNum covers tag and set together, so a word address is built by
   // appending a word index and a zero byte select
   typedef struct packed {
      logic [`CACHE_TAG_BITS+`CACHE_SET_BITS-1:0] blockNum;
      logic [`CACHE_WORD_BITS-1:0]                wordIdx;
      logic                                       byteSel;
   } fillAddrT;

   // both views overlay one 16-bit address word
   typedef union packed {
      lookupAddrT lookup;
      fillAddrT   fill;
   } cacheAddrU;

   // one metadata entry of a way
   // only way 0's lru field is meaningful, it names the way to evict next
   typedef struct packed {
      logic                       lru;
      logic                       valid;
      logic [`CACHE_TAG_BITS-1:0] tag;
   } metaEntryT;

   // memory-side request, a read strobe or a write-through store
   typedef struct packed {
      logic                        read;
      logic                        write;
      logic [`CACHE_ADDR_BITS-1:0] addr;
      wordT                        writeData;
   } memReqT;

endpackage

/* src/metaDataArray.sv */
`timescale 1ns/100ps
`include "cache_params.svh"

module metaDataArray (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic [`CACHE_SET_BITS-1:0] setIdx,
   input  logic                       write,
   input  cachePkg::metaEntryT        dataIn,
   output cachePkg::metaEntryT        dataOut
);

   // one entry per set
   localparam int numSets = 1 << `CACHE_SET_BITS;

   cachePkg::metaEntryT entries [numSets];

   // the lookup needs the entry in the same cycle, so the read is combinational
   assign dataOut = entries[setIdx];

   // reset clears every valid and lru bit, which makes the whole cache empty
   // and points every set's victim at way 0
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < numSets; i++) begin
            entries[i] <= '0;
         end
      end else if (write) begin
         // a write replaces the whole entry, the caller merges fields it keeps
         entries[setIdx] <= dataIn;
      end
   end

endmodule

/* src/dataArray.sv */
`timescale 1ns/100ps
`include "cache_params.svh"

module dataArray (
   input  logic                          clk,
   input  logic [`CACHE_SET_BITS:0]      blockIdx,
   input  logic [`CACHE_WORD_BITS-1:0]   wordIdx,
   input  logic                          write,
   input  cachePkg::wordT                dataIn,
   output cachePkg::wordT                dataOut
);

   // 64 sets times two ways gives 128 blocks, each of eight words
   localparam int numWords = 1 << (`CACHE_SET_BITS + 1 + `CACHE_WORD_BITS);

   cachePkg::wordT                                words [numWords];
   logic [`CACHE_SET_BITS+`CACHE_WORD_BITS:0]     wordAddr;

   // the block index already carries the way in its low bit, so the flat
   // word address is just the block index with the word index appended
   assign wordAddr = {blockIdx, wordIdx};

   // read and write share the one address, reads are combinational
   assign dataOut = words[wordAddr];

   always_ff @(posedge clk) begin
      if (write) begin
         words[wordAddr] <= dataIn;
      end
   end

   // a write through a half-known address would corrupt an unknown block
   writeAddrKnown: assert property (@(posedge clk) write |-> !$isunknown(wordAddr))
      else $error("dataArray write with unknown address %h", wordAddr);

endmodule

/* src/cacheWays.sv */
`timescale 1ns/100ps
`include "cache_params.svh"

module cacheWays (
   input  logic                         clk,
   input  logic                         rstN,
   input  cachePkg::cacheAddrU          addr,
   input  logic                         read,
   input  logic                         write,
   input  cachePkg::wordT               writeData,
   input  logic                         fillActive,
   input  logic                         fillWordWrite,
   input  logic [`CACHE_WORD_BITS-1:0]  fillWordIdx,
   input  cachePkg::wordT               fillWordData,
   input  logic                         fillTagWrite,
   output logic                         hit,
   output cachePkg::wordT               readData
);

   logic [`CACHE_TAG_BITS-1:0]   tag;
   logic [`CACHE_SET_BITS-1:0]   set;
   logic [`CACHE_WORD_BITS:0]    offset;

   cachePkg::metaEntryT          meta0Out;
   cachePkg::metaEntryT          meta1Out;
   cachePkg::metaEntryT          meta0In;
   cachePkg::metaEntryT          meta0Keep;
   cachePkg::metaEntryT          metaNew;
   logic                         meta0Write;
   logic                         meta1Write;

   logic                         hit0;
   logic                         hit1;
   logic                         lruWay;
   logic                         victimQ;
   logic                         wayUsed;
   logic                         accessHit;

   logic                         dataWrite;
   logic [`CACHE_WORD_BITS-1:0]  wordIdx;
   cachePkg::wordT               dataIn;

   // split the CPU address with the lookup view
   assign tag    = addr.lookup.tag;
   assign set    = addr.lookup.set;
   assign offset = addr.lookup.offset;

   metaDataArray metaWay0_i (
      .clk     (clk),
      .rstN    (rstN),
      .setIdx  (set),
      .write   (meta0Write),
      .dataIn  (meta0In),
      .dataOut (meta0Out)
   );

   metaDataArray metaWay1_i (
      .clk     (clk),
      .rstN    (rstN),
      .setIdx  (set),
      .write   (meta1Write),
      .dataIn  (metaNew),
      .dataOut (meta1Out)
   );

   // a way hits when its entry is valid and holds the same tag
   assign hit0 = meta0Out.valid && (meta0Out.tag == tag);
   assign hit1 = meta1Out.valid && (meta1Out.tag == tag);
   assign hit  = hit0 | hit1;

   // the set's LRU bit lives in way 0's entry
   assign lruWay = meta0Out.lru;

   // latch the victim while idle so the whole fill goes to one way,
   // even if the set's lru bit moved in the meantime
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         victimQ <= 1'b0;
      end else if (!fillActive) begin
         victimQ <= lruWay;
      end
   end

   // during a fill the victim wins, otherwise the hitting way, and on a
   // plain miss the lru victim (whose data is then simply not used)
   assign wayUsed = fillActive ? victimQ : (hit1 ? 1'b1 : (hit0 ? 1'b0 : lruWay));

   // a CPU access that hits refreshes the set's LRU bit
   assign accessHit = (read | write) & hit & ~fillActive;

   // the entry written on a fill has valid set and lru pointing away
   // from the way just filled
   assign metaNew = '{lru: ~wayUsed, valid: 1'b1, tag: tag};

   // way 0 keeps its tag and valid bit and only takes the new lru value
   assign meta0Keep = '{lru: ~wayUsed, valid: meta0Out.valid, tag: meta0Out.tag};

   // way 0 is written on every hit and every fill because it holds the lru bit
   assign meta0Write = accessHit | fillTagWrite;
   assign meta0In    = (fillTagWrite && !wayUsed) ? metaNew : meta0Keep;

   // way 1 only changes when it is the fill victim
   assign meta1Write = fillTagWrite & wayUsed;

   // fill words come from memory, store-hit words from the CPU
   assign dataWrite = fillWordWrite | (write & hit & ~fillActive);
   assign wordIdx   = fillWordWrite ? fillWordIdx : offset[`CACHE_WORD_BITS:1];
   assign dataIn    = fillWordWrite ? fillWordData : writeData;

   dataArray dataArray_i (
      .clk      (clk),
      .blockIdx ({set, wayUsed}),
      .wordIdx  (wordIdx),
      .write    (dataWrite),
      .dataIn   (dataIn),
      .dataOut  (readData)
   );

   // a tag is only ever written into the victim, so two ways can never match
   oneWayHits: assert property (@(posedge clk) disable iff (!rstN) !(hit0 && hit1))
      else $error("both ways hit for tag %h set %h", tag, set);

   // the block written by a fill must be found on the very next lookup
   hitAfterFill: assert property (@(posedge clk) disable iff (!rstN)
      (fillTagWrite && read) |=> hit)
      else $error("lookup missed right after fill of set %h", set);

endmodule

/* src/cacheFillFsm.sv */
`timescale 1ns/100ps
`include "cache_params.svh"

module cacheFillFsm (
   input  logic                         clk,
   input  logic                         rstN,
   input  cachePkg::cacheAddrU          addr,
   input  logic                         read,
   input  logic                         hit,
   input  cachePkg::wordT               memReadData,
   input  logic                         memReadValid,
   output logic                         memReadStrobe,
   output cachePkg::cacheAddrU          memWordAddr,
   output logic                         fillActive,
   output logic                         fillWordWrite,
   output logic [`CACHE_WORD_BITS-1:0]  fillWordIdx,
   output cachePkg::wordT               fillWordData,
   output logic                         fillTagWrite
);

   localparam int wordsPerBlock = 1 << `CACHE_WORD_BITS;

   typedef enum logic [1:0] {
      fillIdle,
      fillIssue,
      fillWait
   } fillStateT;

   fillStateT                                       state;
   logic [`CACHE_WORD_BITS-1:0]                     issueCnt;
   logic [`CACHE_WORD_BITS-1:0]                     returnCnt;
   logic [`CACHE_TAG_BITS+`CACHE_SET_BITS-1:0]      blockNum;
   logic                                            lastReturn;

   // the eighth returning word closes the fill
   assign lastReturn = memReadValid && (returnCnt == '1);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= fillIdle;
      end else begin
         case (state)
            // only a read that misses starts a fill, stores never allocate
            fillIdle: begin
               if (read && !hit) begin
                  state <= fillIssue;
               end
            end
            // one strobe per cycle until all eight words are requested
            fillIssue: begin
               if (issueCnt == '1) begin
                  state <= fillWait;
               end
            end
            // with a fixed latency the last word always arrives here
            fillWait: begin
               if (lastReturn) begin
                  state <= fillIdle;
               end
            end
            default: begin
               state <= fillIdle;
            end
         endcase
      end
   end

   // issue counter walks the word index of each strobe
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         issueCnt <= '0;
      end else if (state == fillIssue) begin
         issueCnt <= issueCnt + 1'b1;
      end else begin
         issueCnt <= '0;
      end
   end

   // returns start while strobes are still going out, so count in both
   // busy states and rewind only when idle
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         returnCnt <= '0;
      end else if (state == fillIdle) begin
         returnCnt <= '0;
      end else if (memReadValid) begin
         returnCnt <= returnCnt + 1'b1;
      end
   end

   // the CPU holds its address while stalled, but keep our own copy of the
   // block number so the strobes never depend on that
   always_ff @(posedge clk) begin
      if (state == fillIdle) begin
         blockNum <= addr.fill.blockNum;
      end
   end

   assign memReadStrobe = (state == fillIssue);

   // word address from the fill view, byte select is always the even byte
   always_comb begin
      memWordAddr = '0;
      memWordAddr.fill.blockNum = blockNum;
      memWordAddr.fill.wordIdx  = issueCnt;
      memWordAddr.fill.byteSel  = 1'b0;
   end

   assign fillActive    = (state != fillIdle);
   assign fillWordWrite = fillActive & memReadValid;
   assign fillWordIdx   = returnCnt;
   assign fillWordData  = memReadData;
   assign fillTagWrite  = fillActive & lastReturn;

   // memory only answers our strobes, so data can never show up while idle
   noDataInIdle: assert property (@(posedge clk) disable iff (!rstN)
      memReadValid |-> state != fillIdle)
      else $error("memory data arrived with no fill in progress");

   // every fill sends one unbroken burst of exactly one strobe per word
   strobeBurst: assert property (@(posedge clk) disable iff (!rstN)
      $rose(fillActive) |-> memReadStrobe [*wordsPerBlock] ##1 !memReadStrobe)
      else $error("fill strobe burst has the wrong length");

   // the return counter relies on memory keeping its fixed latency
   fixedLatency: assert property (@(posedge clk) disable iff (!rstN)
      memReadStrobe |-> ##`CACHE_MEM_LATENCY memReadValid)
      else $error("memory did not answer after the expected latency");

endmodule

/* src/cacheSubsystem.sv */
`timescale 1ns/100ps
`include "cache_params.svh"

module cacheSubsystem (
   input  logic                   clk,
   input  logic                   rstN,
   input  cachePkg::cacheAddrU    cpuAddr,
   input  logic                   cpuRead,
   input  logic                   cpuWrite,
   input  cachePkg::wordT         cpuWriteData,
   output cachePkg::wordT         cpuReadData,
   output logic                   cpuStall,
   output cachePkg::memReqT       memReq,
   input  cachePkg::wordT         memReadData,
   input  logic                   memReadValid
);

   logic                          hit;
   logic                          fillActive;
   logic                          fillWordWrite;
   logic [`CACHE_WORD_BITS-1:0]   fillWordIdx;
   cachePkg::wordT                fillWordData;
   logic                          fillTagWrite;
   logic                          memReadStrobe;
   cachePkg::cacheAddrU           memWordAddr;

   cacheWays cacheWays_i (
      .clk           (clk),
      .rstN          (rstN),
      .addr          (cpuAddr),
      .read          (cpuRead),
      .write         (cpuWrite),
      .writeData     (cpuWriteData),
      .fillActive    (fillActive),
      .fillWordWrite (fillWordWrite),
      .fillWordIdx   (fillWordIdx),
      .fillWordData  (fillWordData),
      .fillTagWrite  (fillTagWrite),
      .hit           (hit),
      .readData      (cpuReadData)
   );

   cacheFillFsm cacheFillFsm_i (
      .clk           (clk),
      .rstN          (rstN),
      .addr          (cpuAddr),
      .read          (cpuRead),
      .hit           (hit),
      .memReadData   (memReadData),
      .memReadValid  (memReadValid),
      .memReadStrobe (memReadStrobe),
      .memWordAddr   (memWordAddr),
      .fillActive    (fillActive),
      .fillWordWrite (fillWordWrite),
      .fillWordIdx   (fillWordIdx),
      .fillWordData  (fillWordData),
      .fillTagWrite  (fillTagWrite)
   );

   // a read miss stalls at once, then the fill keeps the CPU held until
   // the block is in and the lookup hits
   assign cpuStall = (cpuRead & ~hit) | fillActive;

   // stores go straight through to memory, fill strobes take the address
   // while they are running
   always_comb begin
      memReq.read      = memReadStrobe;
      memReq.write     = cpuWrite & ~fillActive;
      memReq.addr      = memReadStrobe ? memWordAddr : cpuAddr;
      memReq.writeData = cpuWriteData;
   end

endmodule

/* tb/mainMemoryModel.sv */
`timescale 1ns/100ps
`include "cache_params.svh"

module mainMemoryModel (
   input  logic              clk,
   input  logic              rstN,
   input  cachePkg::memReqT  memReq,
   output cachePkg::wordT    readData,
   output logic              readValid
);

   // one word for every even byte address
   localparam int numWords = 1 << (`CACHE_ADDR_BITS - 1);
   localparam int latency  = `CACHE_MEM_LATENCY;

   // mem is what the cache sees, shadow holds the values the testbench expects
   // and is only ever written by the testbench itself
   cachePkg::wordT                     mem    [numWords];
   cachePkg::wordT                     shadow [numWords];

   logic           [latency-1:0]       validPipe;
   cachePkg::wordT [latency-1:0]       dataPipe;

   // a strobe seen at one edge comes out of the last stage latency edges later,
   // so several reads can be in flight at once
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         validPipe <= '0;
         dataPipe  <= '0;
      end else begin
         validPipe <= {validPipe[latency-2:0], memReq.read};
         dataPipe  <= {dataPipe[latency-2:0], mem[memReq.addr[`CACHE_ADDR_BITS-1:1]]};
      end
   end

   assign readValid = validPipe[latency-1];
   assign readData  = dataPipe[latency-1];

   // write port for write-through stores
   // the testbench preloads mem at time zero as well
   always @(posedge clk) begin
      if (memReq.write) begin
         mem[memReq.addr[`CACHE_ADDR_BITS-1:1]] <= memReq.writeData;
      end
   end

endmodule

/* tb/cacheSubsystemTb.sv */
`timescale 1ns/100ps
`include "cache_params.svh"

module cacheSubsystemTb;

   localparam int resetCycles  = 16;
   localparam int blockWords   = 1 << `CACHE_WORD_BITS;
   // a miss stalls for the latency, the eight strobes and the cycle of the tag write
   localparam int missCycles   = `CACHE_MEM_LATENCY + blockWords + 1;
   localparam int memWords     = 1 << (`CACHE_ADDR_BITS - 1);
   localparam int randomReads  = 200;
   // every access of every test, each given 40 cycles of 10 ns, then doubled
   localparam int accessBudget = 260;
   localparam int watchdogNs   = accessBudget * 40 * 10 * 2;

   logic                  clk;
   logic                  rstN;
   cachePkg::cacheAddrU   cpuAddr;
   logic                  cpuRead;
   logic                  cpuWrite;
   cachePkg::wordT        cpuWriteData;
   cachePkg::wordT        cpuReadData;
   logic                  cpuStall;
   cachePkg::memReqT      memReq;
   cachePkg::wordT        memReadData;
   logic                  memReadValid;

   logic [31:0]           rngState = 32'h48e0_2e6d;
   int                    checkCount;
   int                    valueErrors;
   int                    otherErrors;

   // reference LRU model where one lru bit per set names the next victim
   logic                        modelValid [2][1 << `CACHE_SET_BITS];
   logic [`CACHE_TAG_BITS-1:0]  modelTag   [2][1 << `CACHE_SET_BITS];
   logic                        modelLru   [1 << `CACHE_SET_BITS];

   cacheSubsystem cacheSubsystem_i (
      .clk          (clk),
      .rstN         (rstN),
      .cpuAddr      (cpuAddr),
      .cpuRead      (cpuRead),
      .cpuWrite     (cpuWrite),
      .cpuWriteData (cpuWriteData),
      .cpuReadData  (cpuReadData),
      .cpuStall     (cpuStall),
      .memReq       (memReq),
      .memReadData  (memReadData),
      .memReadValid (memReadValid)
   );

   mainMemoryModel memModel_i (
      .clk       (clk),
      .rstN      (rstN),
      .memReq    (memReq),
      .readData  (memReadData),
      .readValid (memReadValid)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] nextRandom();
      rngState = xorshift32(rngState);
      return rngState;
   endfunction

   function automatic cachePkg::wordT randomWord();
      logic [31:0] r;
      r = nextRandom();
      return r[`CACHE_WORD_WIDTH-1:0];
   endfunction

   function automatic cachePkg::cacheAddrU makeAddr(input logic [`CACHE_TAG_BITS-1:0] tag,
                                                    input logic [`CACHE_SET_BITS-1:0] setIdx,
                                                    input logic [`CACHE_WORD_BITS-1:0] word);
      cachePkg::cacheAddrU a;
      a.lookup.tag    = tag;
      a.lookup.set    = setIdx;
      a.lookup.offset = {word, 1'b0};
      return a;
   endfunction

   function automatic logic modelHit(input cachePkg::cacheAddrU a, output logic way);
      logic h0;
      logic h1;
      h0  = modelValid[0][a.lookup.set] && (modelTag[0][a.lookup.set] == a.lookup.tag);
      h1  = modelValid[1][a.lookup.set] && (modelTag[1][a.lookup.set] == a.lookup.tag);
      way = h1;
      return h0 | h1;
   endfunction

   // a hit points lru at the other way, a read miss fills the victim and
   // points lru away from it, a store miss leaves the set alone
   function automatic void updateModel(input cachePkg::cacheAddrU a, input logic isStore);
      logic way;
      if (modelHit(a, way)) begin
         modelLru[a.lookup.set] = ~way;
      end else if (!isStore) begin
         way = modelLru[a.lookup.set];
         modelValid[way][a.lookup.set] = 1'b1;
         modelTag[way][a.lookup.set]   = a.lookup.tag;
         modelLru[a.lookup.set]        = ~way;
      end
   endfunction

   task automatic checkWord(input string name, input cachePkg::wordT expected,
                            input cachePkg::wordT actual);
      checkCount++;
      if (actual !== expected) begin
         valueErrors++;
         $display("FAILED %s: expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic checkStall(input string name, input logic expected, input logic actual);
      checkCount++;
      if (actual !== expected) begin
         valueErrors++;
         $display("FAILED %s: expected stall %b actual stall %b", name, expected, actual);
      end
   endtask

   task automatic checkMemReq(input string name, input cachePkg::memReqT expected,
                              input cachePkg::memReqT actual);
      cachePkg::memReqT want;
      cachePkg::memReqT got;
      want = expected;
      got  = actual;
      // store data means nothing without a write, and the address nothing when idle
      if (!want.write) begin
         want.writeData = '0;
         got.writeData  = '0;
      end
      if (!want.read && !want.write) begin
         want.addr = '0;
         got.addr  = '0;
      end
      checkCount++;
      if (got !== want) begin
         valueErrors++;
         $display("FAILED %s: expected %h actual %h", name, want, got);
      end
   endtask

   task automatic preloadMemory();
      logic [31:0]                 r;
      logic [`CACHE_ADDR_BITS-2:0] idx;
      cachePkg::wordT              w;
      for (int i = 0; i < memWords; i++) begin
         idx = i[`CACHE_ADDR_BITS-2:0];
         r   = nextRandom();
         // mixing in the index makes each word depend on its whole address
         w   = r[`CACHE_WORD_WIDTH-1:0] ^ {1'b0, idx};
         memModel_i.mem[idx]    = w;
         memModel_i.shadow[idx] = w;
      end
   endtask

   // memory must stay quiet for every reset cycle
   task automatic applyReset(input string name);
      cachePkg::memReqT idleReq;
      idleReq = '0;
      @(negedge clk);
      rstN     = 1'b0;
      cpuRead  = 1'b0;
      cpuWrite = 1'b0;
      repeat (resetCycles) begin
         #2;
         checkMemReq(name, idleReq, memReq);
         @(negedge clk);
      end
      rstN       = 1'b1;
      modelValid = '{default: '0};
      modelTag   = '{default: '0};
      modelLru   = '{default: '0};
   endtask

   // holds the read until the stall falls, checking stall and strobes every cycle
   task automatic doRead(input string name, input cachePkg::cacheAddrU a,
                         input logic expectMiss);
      int                          k;
      int                          stallCycles;
      int                          strobeIdx;
      logic                        done;
      logic                        timedOut;
      logic [`CACHE_ADDR_BITS-2:0] idx;
      cachePkg::memReqT            expReq;
      stallCycles = expectMiss ? missCycles : 0;
      idx         = {a.fill.blockNum, a.fill.wordIdx};
      k           = 0;
      done        = 1'b0;
      timedOut    = 1'b0;
      @(negedge clk);
      cpuAddr  = a;
      cpuRead  = 1'b1;
      cpuWrite = 1'b0;
      while (!done) begin
         #2;
         checkStall(name, k < stallCycles, cpuStall);
         expReq = '0;
         // strobes go out in the eight cycles after the request, word 0 first
         if (expectMiss && k >= 1 && k <= blockWords) begin
            strobeIdx   = k - 1;
            expReq.read = 1'b1;
            expReq.addr = {a.fill.blockNum, strobeIdx[`CACHE_WORD_BITS-1:0], 1'b0};
         end
         checkMemReq(name, expReq, memReq);
         if (!cpuStall) begin
            done = 1'b1;
         end else if (k >= stallCycles + 4) begin
            otherErrors++;
            $display("%s: stall still high after %0d cycles, read abandoned", name, k);
            timedOut = 1'b1;
            done     = 1'b1;
         end else begin
            @(negedge clk);
            k++;
         end
      end
      if (!timedOut) begin
         checkWord(name, memModel_i.shadow[idx], cpuReadData);
      end
      updateModel(a, 1'b0);
      @(negedge clk);
      cpuRead = 1'b0;
   endtask

   task automatic doWrite(input string name, input cachePkg::cacheAddrU a,
                          input cachePkg::wordT data);
      cachePkg::memReqT expReq;
      @(negedge clk);
      cpuAddr      = a;
      cpuRead      = 1'b0;
      cpuWrite     = 1'b1;
      cpuWriteData = data;
      #2;
      expReq           = '0;
      expReq.write     = 1'b1;
      expReq.addr      = a;
      expReq.writeData = data;
      checkStall(name, 1'b0, cpuStall);
      checkMemReq(name, expReq, memReq);
      memModel_i.shadow[{a.fill.blockNum, a.fill.wordIdx}] = data;
      updateModel(a, 1'b1);
      @(negedge clk);
      cpuWrite = 1'b0;
   endtask

   task automatic testColdMiss();
      doRead("testColdMiss", makeAddr(6'h05, 6'h03, 3'd2), 1'b1);
   endtask

   task automatic testHitAllWords();
      for (int w = 0; w < blockWords; w++) begin
         doRead("testHitAllWords", makeAddr(6'h05, 6'h03, w[`CACHE_WORD_BITS-1:0]), 1'b0);
      end
   endtask

   // tags 1, 2 and 3 compete for set 0x10
   task automatic testLruEviction();
      doRead("testLruEviction", makeAddr(6'h01, 6'h10, 3'd0), 1'b1);
      doRead("testLruEviction", makeAddr(6'h02, 6'h10, 3'd0), 1'b1);
      // touching 1 leaves 2 as the victim
      doRead("testLruEviction", makeAddr(6'h01, 6'h10, 3'd1), 1'b0);
      // 3 replaces 2, then 1 must still be there
      doRead("testLruEviction", makeAddr(6'h03, 6'h10, 3'd0), 1'b1);
      doRead("testLruEviction", makeAddr(6'h01, 6'h10, 3'd2), 1'b0);
      // 2 is gone and comes back over 3
      doRead("testLruEviction", makeAddr(6'h02, 6'h10, 3'd4), 1'b1);
      // 3 now evicts 1, then touching 2 makes 3 the victim for 1
      doRead("testLruEviction", makeAddr(6'h03, 6'h10, 3'd5), 1'b1);
      doRead("testLruEviction", makeAddr(6'h02, 6'h10, 3'd6), 1'b0);
      doRead("testLruEviction", makeAddr(6'h01, 6'h10, 3'd7), 1'b1);
   endtask

   task automatic testWriteThrough();
      cachePkg::cacheAddrU hitAddr;
      cachePkg::cacheAddrU missAddr;
      cachePkg::wordT      data;
      // tag 1 of set 0x10 is resident after the eviction test
      hitAddr  = makeAddr(6'h01, 6'h10, 3'd3);
      missAddr = makeAddr(6'h2a, 6'h11, 3'd5);
      data = randomWord();
      doWrite("testWriteThrough", hitAddr, data);
      doRead("testWriteThrough", hitAddr, 1'b0);
      // no allocate, so the read after the store must fetch the new word from memory
      data = randomWord();
      doWrite("testWriteThrough", missAddr, data);
      doRead("testWriteThrough", missAddr, 1'b1);
   endtask

   task automatic testRandomReads();
      logic [31:0]         r;
      logic [1:0]          tagSel;
      logic                way;
      logic                expectMiss;
      cachePkg::cacheAddrU a;
      for (int n = 0; n < randomReads; n++) begin
         r      = nextRandom();
         tagSel = r[3:2];
         if (tagSel == 2'd3) begin
            tagSel = 2'd0;
         end
         // three tags over two ways in four sets keeps hits and misses mixed
         a = makeAddr(6'h08 + {4'b0, tagSel}, 6'h20 + {4'b0, r[1:0]}, r[6:4]);
         expectMiss = !modelHit(a, way);
         doRead("testRandomReads", a, expectMiss);
      end
   endtask

   task automatic testResetClears();
      cachePkg::cacheAddrU a;
      cachePkg::cacheAddrU b;
      a = makeAddr(6'h01, 6'h10, 3'd3);
      b = makeAddr(6'h15, 6'h2c, 3'd1);
      doRead("testResetClears", a, 1'b0);
      // start a miss and cut it off with reset while its strobes are going out
      @(negedge clk);
      cpuAddr  = b;
      cpuRead  = 1'b1;
      cpuWrite = 1'b0;
      repeat (2) @(negedge clk);
      #2;
      checkStall("testResetClears", 1'b1, cpuStall);
      applyReset("testResetClears");
      doRead("testResetClears", a, 1'b1);
   endtask

   initial begin
      #(watchdogNs);
      $display("watchdog expired after %0d ns, the tests did not finish", watchdogNs);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      clk          = 1'b0;
      rstN         = 1'b0;
      cpuAddr      = '0;
      cpuRead      = 1'b0;
      cpuWrite     = 1'b0;
      cpuWriteData = '0;
      checkCount   = 0;
      valueErrors  = 0;
      otherErrors  = 0;
      preloadMemory();
      applyReset("initialReset");
      testColdMiss();
      testHitAllWords();
      testLruEviction();
      testWriteThrough();
      testRandomReads();
      testResetClears();
      $display("checks %0d, value mismatches %0d, other errors %0d",
               checkCount, valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* cacheSubsystem.f */
+incdir+src
src/cachePkg.sv
src/metaDataArray.sv
src/dataArray.sv
src/cacheWays.sv
src/cacheFillFsm.sv
src/cacheSubsystem.sv
tb/mainMemoryModel.sv
tb/cacheSubsystemTb.sv

/* Makefile */
# Verilator build for the two-way cache subsystem

VERILATOR ?= verilator
TOP       ?= cacheSubsystemTb
RTL_TOP   ?= cacheSubsystem
FILELIST  ?= cacheSubsystem.f
SEED      ?= 1
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= -sv --timing --assert --timescale 1ns/100ps

SOURCES := $(wildcard src/*.sv src/*.svh tb/*.sv)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(VFLAGS) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --binary --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, so a crashed run also counts as a failure
sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) +verilator+rand+reset+2 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '** PASS **' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
